// ==== hw/corr_pkg.sv ====
`default_nettype none

package corr_pkg;

   // input sample part width.
   localparam int SAMPLE_W   = 16;

   // normalized part width.
   localparam int NORM_W     = 8;

   // ratio scale, multiply by 128.
   localparam int NORM_SHIFT = 7;

   // one divider iteration per dividend bit.
   localparam int DIVIDEND_W = SAMPLE_W + NORM_SHIFT;
   localparam int DIVISOR_W  = SAMPLE_W + 1;

   localparam int SCORE_W    = 2 * NORM_W;

   typedef enum logic [1:0] {
      DIV_IDLE,
      DIV_RUN,
      DIV_DONE
   } div_state_t;

   typedef enum logic [1:0] {
      NORM_IDLE,
      NORM_MAG,
      NORM_DIV,
      NORM_HOLD
   } norm_state_t;

endpackage

`default_nettype wire

// ==== hw/seq_divider.sv ====
`timescale 1ns/100ps
`default_nettype none

module seq_divider import corr_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  logic [DIVIDEND_W-1:0] dividend,
   input  logic [DIVISOR_W-1:0]  divisor,
   output logic [NORM_W-1:0]     quotient,
   output logic                  done
);

   localparam int CNT_W = $clog2(DIVIDEND_W);

   div_state_t            state;
   logic [CNT_W-1:0]      count;
   logic [DIVISOR_W-1:0]  reg_b;
   logic [DIVISOR_W-1:0]  remainder;
   logic [DIVIDEND_W-1:0] data_a;
   logic [DIVISOR_W:0]    partial;
   logic [DIVISOR_W:0]    diff;
   logic                  q_bit;

   // next dividend bit moves into the partial remainder.
   assign partial = {remainder, data_a[DIVIDEND_W-1]};
   assign diff    = partial - {1'b0, reg_b};
   assign q_bit   = (partial >= {1'b0, reg_b});

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         state <= DIV_IDLE;
         count <= '0;
      end
      else
      begin
         case (state)
            DIV_IDLE, DIV_DONE:
            begin
               if (start)
               begin
                  state <= DIV_RUN;
                  count <= '0;
               end
            end
            DIV_RUN:
            begin
               count <= count + 1'b1;
               if (count == CNT_W'(DIVIDEND_W - 1))
                  state <= DIV_DONE;
            end
            default:
            begin
               state <= DIV_IDLE;
            end
         endcase
      end
   end

   // restoring step, subtract only when the divisor fits.
   always_ff @(posedge clk)
   begin
      if (start && state != DIV_RUN)
      begin
         reg_b     <= divisor;
         data_a    <= dividend;
         remainder <= '0;
      end
      else if (state == DIV_RUN)
      begin
         remainder <= q_bit ? diff[DIVISOR_W-1:0] : partial[DIVISOR_W-1:0];
         data_a    <= {data_a[DIVIDEND_W-2:0], q_bit};
      end
   end

   // ratio is below 128, so the low bits hold the whole quotient.
   assign quotient = data_a[NORM_W-1:0];
   assign done     = (state == DIV_DONE);

endmodule

`default_nettype wire

// ==== hw/norm_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module norm_stage import corr_pkg::*; (
   input  logic                       clk,
   input  logic                       rst,
   input  logic signed [SAMPLE_W-1:0] in_re,
   input  logic signed [SAMPLE_W-1:0] in_im,
   input  logic                       in_valid,
   output logic                       in_ready,
   output logic [NORM_W-1:0]          n_re,
   output logic [NORM_W-1:0]          n_im,
   output logic                       n_valid,
   input  logic                       n_ready
);

   norm_state_t                state;
   logic signed [SAMPLE_W-1:0] re_q;
   logic signed [SAMPLE_W-1:0] im_q;
   logic [SAMPLE_W-1:0]        mag_re;
   logic [SAMPLE_W-1:0]        mag_im;
   logic [DIVISOR_W-1:0]       div_sum;
   logic [DIVIDEND_W-1:0]      dvd_re;
   logic [DIVIDEND_W-1:0]      dvd_im;
   logic                       div_start;
   logic                       done_re;
   logic                       done_im;

   assign in_ready  = (state == NORM_IDLE);
   assign n_valid   = (state == NORM_HOLD);
   assign div_start = (state == NORM_MAG);

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
      begin
         re_q <= in_re;
         im_q <= in_im;
      end
   end

   // two's complement magnitudes, -32768 maps to 32768.
   assign mag_re = re_q[SAMPLE_W-1] ? SAMPLE_W'(-re_q) : re_q;
   assign mag_im = im_q[SAMPLE_W-1] ? SAMPLE_W'(-im_q) : im_q;

   // the +1 keeps an all-zero sample away from a zero divisor.
   assign div_sum = {1'b0, mag_re} + {1'b0, mag_im} + 1'b1;
   assign dvd_re  = {mag_re, {NORM_SHIFT{1'b0}}};
   assign dvd_im  = {mag_im, {NORM_SHIFT{1'b0}}};

   always_ff @(posedge clk)
   begin
      if (!rst)
         state <= NORM_IDLE;
      else
      begin
         case (state)
            NORM_IDLE:
            begin
               if (in_valid)
                  state <= NORM_MAG;
            end
            NORM_MAG:
            begin
               state <= NORM_DIV;
            end
            NORM_DIV:
            begin
               if (done_re && done_im)
                  state <= NORM_HOLD;
            end
            NORM_HOLD:
            begin
               if (n_ready)
                  state <= NORM_IDLE;
            end
            default:
            begin
               state <= NORM_IDLE;
            end
         endcase
      end
   end

   // quotients stay put in the dividers until the next start.
   seq_divider u_div_re (
      .clk      (clk),
      .rst      (rst),
      .start    (div_start),
      .dividend (dvd_re),
      .divisor  (div_sum),
      .quotient (n_re),
      .done     (done_re)
   );

   seq_divider u_div_im (
      .clk      (clk),
      .rst      (rst),
      .start    (div_start),
      .dividend (dvd_im),
      .divisor  (div_sum),
      .quotient (n_im),
      .done     (done_im)
   );

endmodule

`default_nettype wire

// ==== hw/corr_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

module corr_lane import corr_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               advance,
   input  logic [NORM_W-1:0]  l_re,
   input  logic [NORM_W-1:0]  l_im,
   input  logic [NORM_W-1:0]  r_re,
   input  logic [NORM_W-1:0]  r_im,
   output logic [SCORE_W-1:0] score
);

   logic [SCORE_W-1:0] prod_re;
   logic [SCORE_W-1:0] prod_im;

   // products first, then their sum one step later.
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         prod_re <= '0;
         prod_im <= '0;
         score   <= '0;
      end
      else if (advance)
      begin
         prod_re <= l_re * r_re;
         prod_im <= l_im * r_im;
         score   <= prod_re + prod_im;
      end
   end

endmodule

`default_nettype wire

// ==== hw/corr_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module corr_array import corr_pkg::*; #(
   parameter int NUM_DISP = 6
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        l_valid,
   output logic                        l_ready,
   input  logic [NORM_W-1:0]           l_re,
   input  logic [NORM_W-1:0]           l_im,
   input  logic                        r_valid,
   output logic                        r_ready,
   input  logic [NORM_W-1:0]           r_re,
   input  logic [NORM_W-1:0]           r_im,
   output logic [NUM_DISP*SCORE_W-1:0] scores,
   output logic [$clog2(NUM_DISP)-1:0] best_disp,
   output logic                        out_valid,
   input  logic                        out_ready
);

   localparam int DISP_W = $clog2(NUM_DISP);

   logic               advance;
   logic               pair;
   logic               lane_adv;
   logic [NORM_W-1:0]  tap_re [NUM_DISP];
   logic [NORM_W-1:0]  tap_im [NUM_DISP];
   logic [NORM_W-1:0]  r_re_q;
   logic [NORM_W-1:0]  r_im_q;
   logic [2:0]         vld;
   logic [SCORE_W-1:0] lane_score [NUM_DISP];
   logic [DISP_W-1:0]  best_idx;
   logic [SCORE_W-1:0] best_val;

   // a held result freezes the whole array.
   assign advance  = !out_valid || out_ready;
   assign pair     = l_valid && r_valid && advance;
   assign l_ready  = r_valid && advance;
   assign r_ready  = l_valid && advance;

   // lanes only clock while a tap or product stage holds data.
   assign lane_adv = advance && (vld[0] || vld[1]);

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         tap_re <= '{default: '0};
         tap_im <= '{default: '0};
         vld    <= '0;
      end
      else if (advance)
      begin
         vld <= {vld[1:0], pair};
         if (pair)
         begin
            tap_re[0] <= l_re;
            tap_im[0] <= l_im;
            for (int k = 1; k < NUM_DISP; k++)
            begin
               tap_re[k] <= tap_re[k-1];
               tap_im[k] <= tap_im[k-1];
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (pair)
      begin
         r_re_q <= r_re;
         r_im_q <= r_im;
      end
   end

   for (genvar k = 0; k < NUM_DISP; k++)
   begin : g_lane
      corr_lane u_lane (
         .clk     (clk),
         .rst     (rst),
         .advance (lane_adv),
         .l_re    (tap_re[k]),
         .l_im    (tap_im[k]),
         .r_re    (r_re_q),
         .r_im    (r_im_q),
         .score   (lane_score[k])
      );
   end

   // strict compare keeps the lowest index on a tie.
   always_comb
   begin
      best_idx = '0;
      best_val = lane_score[0];
      for (int k = 1; k < NUM_DISP; k++)
      begin
         if (lane_score[k] > best_val)
         begin
            best_idx = DISP_W'(k);
            best_val = lane_score[k];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         scores    <= '0;
         best_disp <= '0;
         out_valid <= 1'b0;
      end
      else if (advance)
      begin
         out_valid <= vld[2];
         if (vld[2])
         begin
            for (int k = 0; k < NUM_DISP; k++)
               scores[k*SCORE_W +: SCORE_W] <= lane_score[k];
            best_disp <= best_idx;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/stereo_corr_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module stereo_corr_top import corr_pkg::*; #(
   parameter int NUM_DISP = 6
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic signed [SAMPLE_W-1:0]  l_re,
   input  logic signed [SAMPLE_W-1:0]  l_im,
   input  logic                        l_valid,
   output logic                        l_ready,
   input  logic signed [SAMPLE_W-1:0]  r_re,
   input  logic signed [SAMPLE_W-1:0]  r_im,
   input  logic                        r_valid,
   output logic                        r_ready,
   output logic [NUM_DISP*SCORE_W-1:0] scores,
   output logic [$clog2(NUM_DISP)-1:0] best_disp,
   output logic                        out_valid,
   input  logic                        out_ready
);

   logic [NORM_W-1:0] ln_re;
   logic [NORM_W-1:0] ln_im;
   logic              ln_valid;
   logic              ln_ready;
   logic [NORM_W-1:0] rn_re;
   logic [NORM_W-1:0] rn_im;
   logic              rn_valid;
   logic              rn_ready;

   norm_stage u_norm_l (
      .clk      (clk),
      .rst      (rst),
      .in_re    (l_re),
      .in_im    (l_im),
      .in_valid (l_valid),
      .in_ready (l_ready),
      .n_re     (ln_re),
      .n_im     (ln_im),
      .n_valid  (ln_valid),
      .n_ready  (ln_ready)
   );

   norm_stage u_norm_r (
      .clk      (clk),
      .rst      (rst),
      .in_re    (r_re),
      .in_im    (r_im),
      .in_valid (r_valid),
      .in_ready (r_ready),
      .n_re     (rn_re),
      .n_im     (rn_im),
      .n_valid  (rn_valid),
      .n_ready  (rn_ready)
   );

   corr_array #(
      .NUM_DISP (NUM_DISP)
   ) u_array (
      .clk       (clk),
      .rst       (rst),
      .l_valid   (ln_valid),
      .l_ready   (ln_ready),
      .l_re      (ln_re),
      .l_im      (ln_im),
      .r_valid   (rn_valid),
      .r_ready   (rn_ready),
      .r_re      (rn_re),
      .r_im      (rn_im),
      .scores    (scores),
      .best_disp (best_disp),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

// ==== test/stereo_corr_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module stereo_corr_checker import corr_pkg::*; #(
   parameter int NUM_DISP = 6
) (
   input logic                        clk,
   input logic                        rst,
   input logic                        l_ready,
   input logic                        r_ready,
   input logic [NUM_DISP*SCORE_W-1:0] scores,
   input logic [$clog2(NUM_DISP)-1:0] best_disp,
   input logic                        out_valid,
   input logic                        out_ready
);

   // a held result keeps its values until it is taken.
   a_hold: assert property (@(posedge clk) disable iff (!rst)
      out_valid && !out_ready |=> out_valid && $stable(scores) && $stable(best_disp))
      else $error("output result changed while waiting for out_ready");

   a_best_range: assert property (@(posedge clk) disable iff (!rst)
      out_valid |-> (32'(best_disp) < NUM_DISP))
      else $error("best_disp is outside the disparity window");

   // both inputs ready and no output once reset has been seen.
   a_reset_state: assert property (@(posedge clk)
      !rst |=> l_ready && r_ready && !out_valid)
      else $error("inputs not ready or output pending after reset");

endmodule

bind stereo_corr_top stereo_corr_checker #(
   .NUM_DISP (NUM_DISP)
) u_checker (
   .clk       (clk),
   .rst       (rst),
   .l_ready   (l_ready),
   .r_ready   (r_ready),
   .scores    (scores),
   .best_disp (best_disp),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

`default_nettype wire

// ==== test/stereo_corr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module stereo_corr_tb import corr_pkg::*; ();

   localparam int NUM_DISP    = 6;
   localparam int DISP_W      = $clog2(NUM_DISP);
   localparam int NUM_RES     = 300;
   localparam int RESET_AT    = 150;
   localparam int STALL_LIMIT = 500;

   logic                        clk;
   logic                        rst;
   logic signed [SAMPLE_W-1:0]  l_re;
   logic signed [SAMPLE_W-1:0]  l_im;
   logic                        l_valid;
   logic                        l_ready;
   logic signed [SAMPLE_W-1:0]  r_re;
   logic signed [SAMPLE_W-1:0]  r_im;
   logic                        r_valid;
   logic                        r_ready;
   logic [NUM_DISP*SCORE_W-1:0] scores;
   logic [DISP_W-1:0]           best_disp;
   logic                        out_valid;
   logic                        out_ready;

   integer seed;
   int     errors;
   int     results;
   int     idle_cycles;
   bit     timed_out;
   bit     mid_reset_done;
   bit     l_fire;
   bit     r_fire;
   bit     held;

   // reference model state.
   logic [NORM_W-1:0]           lq_re [$];
   logic [NORM_W-1:0]           lq_im [$];
   logic [NORM_W-1:0]           rq_re [$];
   logic [NORM_W-1:0]           rq_im [$];
   logic [NORM_W-1:0]           mtap_re [NUM_DISP];
   logic [NORM_W-1:0]           mtap_im [NUM_DISP];
   logic [NUM_DISP*SCORE_W-1:0] exp_scores [$];
   logic [DISP_W-1:0]           exp_best [$];
   logic [NUM_DISP*SCORE_W-1:0] held_scores;
   logic [DISP_W-1:0]           held_best;

   stereo_corr_top #(
      .NUM_DISP (NUM_DISP)
   ) UUT (
      .clk       (clk),
      .rst       (rst),
      .l_re      (l_re),
      .l_im      (l_im),
      .l_valid   (l_valid),
      .l_ready   (l_ready),
      .r_re      (r_re),
      .r_im      (r_im),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .scores    (scores),
      .best_disp (best_disp),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // floor(|part| * 128 / (|re| + |im| + 1)).
   function automatic logic [NORM_W-1:0] norm_part(input int part, input int other);
      int mag_p;
      int mag_o;
      mag_p = (part < 0) ? -part : part;
      mag_o = (other < 0) ? -other : other;
      return NORM_W'((mag_p << NORM_SHIFT) / (mag_p + mag_o + 1));
   endfunction

   task automatic clear_model();
      lq_re.delete();
      lq_im.delete();
      rq_re.delete();
      rq_im.delete();
      exp_scores.delete();
      exp_best.delete();
      for (int k = 0; k < NUM_DISP; k++)
      begin
         mtap_re[k] = '0;
         mtap_im[k] = '0;
      end
      held   = 1'b0;
      l_fire = 1'b0;
      r_fire = 1'b0;
   endtask

   // pairs the n-th left with the n-th right sample.
   task automatic pair_samples();
      logic [NUM_DISP*SCORE_W-1:0] sc;
      logic [SCORE_W-1:0]          s;
      logic [SCORE_W-1:0]          best_val;
      logic [DISP_W-1:0]           best;
      logic [NORM_W-1:0]           rre;
      logic [NORM_W-1:0]           rim;
      while (lq_re.size() > 0 && rq_re.size() > 0)
      begin
         for (int k = NUM_DISP - 1; k > 0; k--)
         begin
            mtap_re[k] = mtap_re[k-1];
            mtap_im[k] = mtap_im[k-1];
         end
         mtap_re[0] = lq_re.pop_front();
         mtap_im[0] = lq_im.pop_front();
         rre = rq_re.pop_front();
         rim = rq_im.pop_front();
         sc = '0;
         best = '0;
         best_val = '0;
         for (int k = 0; k < NUM_DISP; k++)
         begin
            s = SCORE_W'(mtap_re[k]) * SCORE_W'(rre) + SCORE_W'(mtap_im[k]) * SCORE_W'(rim);
            sc[k*SCORE_W +: SCORE_W] = s;
            if (k == 0 || s > best_val)
            begin
               best = DISP_W'(k);
               best_val = s;
            end
         end
         exp_scores.push_back(sc);
         exp_best.push_back(best);
      end
   endtask

   // zeros, repeats and large negative parts show up often.
   task automatic new_sample(input logic signed [SAMPLE_W-1:0] prev_re,
                             input logic signed [SAMPLE_W-1:0] prev_im,
                             output logic signed [SAMPLE_W-1:0] re,
                             output logic signed [SAMPLE_W-1:0] im);
      int kind;
      kind = $random(seed) & 7;
      re = SAMPLE_W'($random(seed));
      im = SAMPLE_W'($random(seed));
      case (kind)
         0:
         begin
            re = '0;
            im = '0;
         end
         1:
         begin
            re = prev_re;
            im = prev_im;
         end
         2:
         begin
            re = {1'b1, {(SAMPLE_W-1){1'b0}}};
         end
         3:
         begin
            re[SAMPLE_W-1] = 1'b1;
            im[SAMPLE_W-1] = 1'b1;
         end
         default:
         begin
         end
      endcase
   endtask

   task automatic apply_reset();
      rst       = 1'b0;
      l_valid   = 1'b0;
      r_valid   = 1'b0;
      out_ready = 1'b0;
      l_re      = '0;
      l_im      = '0;
      r_re      = '0;
      r_im      = '0;
      idle_cycles = 0;
      clear_model();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
   endtask

   task automatic check_reset_state();
      if (out_valid !== 1'b0)
      begin
         $display("Fail out_valid after reset: got %h expected %h", out_valid, 1'b0);
         errors++;
      end
      if (l_ready !== 1'b1)
      begin
         $display("Fail l_ready after reset: got %h expected %h", l_ready, 1'b1);
         errors++;
      end
      if (r_ready !== 1'b1)
      begin
         $display("Fail r_ready after reset: got %h expected %h", r_ready, 1'b1);
         errors++;
      end
   endtask

   task automatic check_output();
      logic [NUM_DISP*SCORE_W-1:0] exp_s;
      logic [DISP_W-1:0]           exp_b;
      if (held)
      begin
         if (out_valid !== 1'b1)
         begin
            $display("Fail out_valid while held: got %h expected %h", out_valid, 1'b1);
            errors++;
         end
         if (scores !== held_scores)
         begin
            $display("Fail scores while held: got %h expected %h", scores, held_scores);
            errors++;
         end
         if (best_disp !== held_best)
         begin
            $display("Fail best_disp while held: got %h expected %h", best_disp, held_best);
            errors++;
         end
      end
      if (out_valid && out_ready)
      begin
         if (exp_scores.size() == 0)
         begin
            $display("output transfer %0d arrived with no expected result pending", results);
            errors++;
         end
         else
         begin
            exp_s = exp_scores.pop_front();
            exp_b = exp_best.pop_front();
            if (scores !== exp_s)
            begin
               $display("Fail scores (result %0d): got %h expected %h", results, scores, exp_s);
               errors++;
            end
            if (best_disp !== exp_b)
            begin
               $display("Fail best_disp (result %0d): got %h expected %h",
                        results, best_disp, exp_b);
               errors++;
            end
         end
         results++;
         idle_cycles = 0;
      end
      held        = out_valid && !out_ready;
      held_scores = scores;
      held_best   = best_disp;
   endtask

   // called on a falling edge; transfers land on the next rising edge.
   task automatic step_cycle();
      logic signed [SAMPLE_W-1:0] nre;
      logic signed [SAMPLE_W-1:0] nim;
      out_ready = (($random(seed) & 3) != 0);
      if (!(l_valid && !l_fire))
      begin
         new_sample(l_re, l_im, nre, nim);
         l_re    = nre;
         l_im    = nim;
         l_valid = (($random(seed) & 3) != 0);
      end
      if (!(r_valid && !r_fire))
      begin
         new_sample(r_re, r_im, nre, nim);
         r_re    = nre;
         r_im    = nim;
         r_valid = (($random(seed) & 3) != 0);
      end
      #1;
      check_output();
      l_fire = l_valid && l_ready;
      r_fire = r_valid && r_ready;
      if (l_fire)
      begin
         lq_re.push_back(norm_part(int'(l_re), int'(l_im)));
         lq_im.push_back(norm_part(int'(l_im), int'(l_re)));
      end
      if (r_fire)
      begin
         rq_re.push_back(norm_part(int'(r_re), int'(r_im)));
         rq_im.push_back(norm_part(int'(r_im), int'(r_re)));
      end
      pair_samples();
   endtask

   initial
   begin
      seed           = 32'h88bc6a6c;
      errors         = 0;
      results        = 0;
      idle_cycles    = 0;
      timed_out      = 1'b0;
      mid_reset_done = 1'b0;
      apply_reset();
      check_reset_state();
      while (results < NUM_RES && !timed_out)
      begin
         @(negedge clk);
         if (results == RESET_AT && !mid_reset_done)
         begin
            apply_reset();
            check_reset_state();
            mid_reset_done = 1'b1;
         end
         else
         begin
            step_cycle();
            idle_cycles++;
            if (idle_cycles > STALL_LIMIT)
            begin
               $display("timed out after %0d cycles without an output transfer", idle_cycles);
               errors++;
               timed_out = 1'b1;
            end
         end
      end
      $display("errors %0d, results checked %0d", errors, results);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
hw/corr_pkg.sv
hw/seq_divider.sv
hw/norm_stage.sv
hw/corr_lane.sv
hw/corr_array.sv
hw/stereo_corr_top.sv
test/stereo_corr_checker.sv
test/stereo_corr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the stereo correlator testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module stereo_corr_tb -o stereo_corr_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/stereo_corr_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "Test passed" "$log"; then
   echo "simulation passed"
   exit 0
fi

echo "pass message not found in $log"
exit 1
